// File: Makefile
# Verilator build and run of the branch predictor testbench
VERILATOR ?= verilator
TOP       ?= tb_branch_predictor
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

SOURCES := $(wildcard source/*.sv source/*.svh sim/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# the log decides pass or fail, not the exit status of the simulation
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/100ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/tb_branch_predictor.sv
/* directed steps plus LFSR-driven counter training, one step per cycle.
   expected values assume the default sizes in bp_settings.svh */
`default_nettype none
`timescale 1ns/100ps
`include "bp_settings.svh"

module tb_branch_predictor;

	localparam int RESET_CYCLES = 16;
	localparam int RANDOM_STEPS = 48;
	localparam int MARGIN       = 50;
	localparam predictor_pkg::branch_class_t C_NONE = predictor_pkg::CLASS_NONE;
	localparam predictor_pkg::branch_class_t C_COND = predictor_pkg::CLASS_COND;
	localparam predictor_pkg::branch_class_t C_JUMP = predictor_pkg::CLASS_JUMP;
	localparam predictor_pkg::branch_class_t C_CALL = predictor_pkg::CLASS_CALL;
	localparam predictor_pkg::branch_class_t C_RET  = predictor_pkg::CLASS_RETURN;
	localparam predictor_pkg::branch_class_t C_IND  = predictor_pkg::CLASS_INDIRECT;

	// one table row: what is driven in a cycle and what must come back
	typedef struct packed {
		logic                         enable;
		logic                         fetch_valid;
		logic [`BP_XLEN-1:0]          fetch_pc;
		rv_isa_pkg::instr_word_t      fetch_instr;
		logic                         retire_valid;
		logic [`BP_XLEN-1:0]          retire_pc;
		predictor_pkg::branch_class_t retire_class;
		logic                         retire_taken;
		logic [`BP_XLEN-1:0]          retire_target;
		predictor_pkg::branch_class_t exp_class;
		logic                         exp_valid;
		logic                         exp_taken;
		logic [`BP_XLEN-1:0]          exp_target;
	} step_t;

	logic                         clock;
	logic                         reset;
	logic                         enable;
	logic                         fetch_valid;
	logic [`BP_XLEN-1:0]          fetch_pc;
	rv_isa_pkg::instr_word_t      fetch_instr;
	logic                         retire_valid;
	logic [`BP_XLEN-1:0]          retire_pc;
	predictor_pkg::branch_class_t retire_class;
	logic                         retire_taken;
	logic [`BP_XLEN-1:0]          retire_target;
	logic                         predict_valid;
	logic                         predict_taken;
	logic [`BP_XLEN-1:0]          predict_target;

	step_t       steps [$];
	string       names [$];
	step_t       pending;                   // retire half of the step being built
	int          pht_model [`BP_PHT_ROWS]; // 0 strong not-taken .. 3 strong taken
	logic [16:0] lfsr;
	int          errors = 0;
	int          cycle_count = 0;
	int          cycle_limit = 0;

	branch_predictor i_branch_predictor (.*);

	always #10 clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("timeout: the step table did not finish within %0d cycles", cycle_limit);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// x^17 + x^14 + 1
	function automatic logic [16:0] lfsr_step(input logic [16:0] state);
		return {state[15:0], state[16] ^ state[13]};
	endfunction

	task automatic take_bits(input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++) begin
			lfsr  = lfsr_step(lfsr);
			value = (value << 1) | lfsr[0];
		end
	endtask

	function automatic rv_isa_pkg::instr_word_t encode_branch(input int offset);
		rv_isa_pkg::instr_word_t word;
		word.raw        = 32'h0;
		word.b.imm_12   = offset[12];
		word.b.imm_11   = offset[11];
		word.b.imm_10_5 = offset[10:5];
		word.b.imm_4_1  = offset[4:1];
		word.b.rs1      = 5'd10;
		word.b.rs2      = 5'd11;
		word.b.funct3   = 3'b001; // bne
		word.b.opcode   = rv_isa_pkg::OP_BRANCH;
		return word;
	endfunction

	function automatic rv_isa_pkg::instr_word_t encode_jal(input logic [4:0] rd, input int offset);
		rv_isa_pkg::instr_word_t word;
		word.j.imm_20    = offset[20];
		word.j.imm_19_12 = offset[19:12];
		word.j.imm_11    = offset[11];
		word.j.imm_10_1  = offset[10:1];
		word.j.rd        = rd;
		word.j.opcode    = rv_isa_pkg::OP_JAL;
		return word;
	endfunction

	function automatic rv_isa_pkg::instr_word_t encode_jalr(input logic [4:0] rd,
			input logic [4:0] rs1);
		rv_isa_pkg::instr_word_t word;
		word.raw = {12'd0, rs1, 3'd0, rd, rv_isa_pkg::OP_JALR};
		return word;
	endfunction

	// sets the retire of the next step and trains the model, so that step sees it
	task automatic retire_next(input logic en, input logic [`BP_XLEN-1:0] pc,
			input predictor_pkg::branch_class_t cls, input logic taken,
			input logic [`BP_XLEN-1:0] target);
		int row;
		pending.enable        = en;
		pending.retire_valid  = 1'b1;
		pending.retire_pc     = pc;
		pending.retire_class  = cls;
		pending.retire_taken  = taken;
		pending.retire_target = target;
		row = (pc >> 2) % `BP_PHT_ROWS;
		if (en && cls == C_COND) begin
			if (taken && pht_model[row] < 3)
				pht_model[row]++;
			else if (!taken && pht_model[row] > 0)
				pht_model[row]--;
		end
	endtask

	task automatic push_step(input string name, input logic valid,
			input logic [`BP_XLEN-1:0] pc, input rv_isa_pkg::instr_word_t instr,
			input predictor_pkg::branch_class_t cls, input logic exp_valid,
			input logic exp_taken, input logic [`BP_XLEN-1:0] exp_target);
		pending.fetch_valid = valid;
		pending.fetch_pc    = pc;
		pending.fetch_instr = instr;
		pending.exp_class   = cls;
		pending.exp_valid   = exp_valid;
		pending.exp_taken   = exp_taken;
		pending.exp_target  = exp_target;
		steps.push_back(pending);
		names.push_back(name);
		pending        = '0;
		pending.enable = 1'b1;
	endtask

	task automatic build_table();
		logic [0:8]          train_taken  = 9'b111100001;
		logic [0:8]          train_expect = 9'b011110000;
		int                  row;
		int                  taken;
		int                  fetch_row;
		logic [`BP_XLEN-1:0] pc;
		// counter of row 0 up to strong taken, down to strong not-taken, one more taken
		push_step("cond_after_reset", 1, 32'h100, encode_branch(64), C_COND, 1, 0, 32'h140);
		for (int k = 0; k < 9; k++) begin
			retire_next(1, 32'h100, C_COND, train_taken[k], 32'h0);
			push_step($sformatf("cond_train_%0d", k), 1, 32'h100, encode_branch(64), C_COND,
				1, train_expect[k], 32'h140);
		end
		retire_next(1, 32'h100, C_RET, 1, 32'h0);
		push_step("return_no_train", 1, 32'h100, encode_branch(64), C_COND, 1, 0, 32'h140);
		push_step("jal_forward", 1, 32'h400, encode_jal(0, 32'h800), C_JUMP, 1, 1, 32'hC00);
		push_step("jal_backward", 1, 32'h200000, encode_jal(0, -32'h100000), C_JUMP,
			1, 1, 32'h100000);
		push_step("branch_backward", 1, 32'h2008, encode_branch(-4096), C_COND, 1, 0, 32'h1008);
		push_step("branch_forward_max", 1, 32'h3004, encode_branch(4094), C_COND, 1, 0, 32'h4002);
		push_step("ret_empty", 1, 32'h610, encode_jalr(0, 1), C_RET, 1, 0, 32'h614);
		push_step("call", 1, 32'h500, encode_jal(1, 32'h100), C_CALL, 1, 1, 32'h600);
		push_step("ret_after_call", 1, 32'h600, encode_jalr(0, 1), C_RET, 1, 1, 32'h504);
		push_step("call_outer", 1, 32'h700, encode_jal(1, 32'h100), C_CALL, 1, 1, 32'h800);
		push_step("call_inner", 1, 32'h800, encode_jal(1, 32'h100), C_CALL, 1, 1, 32'h900);
		push_step("ret_inner", 1, 32'h900, encode_jalr(0, 1), C_RET, 1, 1, 32'h804);
		push_step("ret_outer", 1, 32'h804, encode_jalr(0, 1), C_RET, 1, 1, 32'h704);
		push_step("ret_drained", 1, 32'h708, encode_jalr(0, 1), C_RET, 1, 0, 32'h70C);
		push_step("btb_miss", 1, 32'hA08, encode_jalr(5, 6), C_IND, 1, 0, 32'hA0C);
		retire_next(1, 32'hA08, C_IND, 1, 32'h12345678);
		push_step("btb_write_cycle", 1, 32'hA08, encode_jalr(5, 6), C_IND, 1, 0, 32'hA0C);
		push_step("btb_hit", 1, 32'hA08, encode_jalr(5, 6), C_IND, 1, 1, 32'h12345678);
		push_step("btb_alias", 1, 32'hA28, encode_jalr(5, 6), C_IND, 1, 0, 32'hA2C);
		// training frozen, row 0 stays weak not-taken and the buffer keeps its entry
		retire_next(0, 32'h100, C_COND, 1, 32'h0);
		push_step("pht_frozen", 1, 32'h100, encode_branch(64), C_COND, 1, 0, 32'h140);
		retire_next(0, 32'hA08, C_IND, 1, 32'h55AA0000);
		push_step("pht_still_frozen", 1, 32'h100, encode_branch(64), C_COND, 1, 0, 32'h140);
		retire_next(0, 32'hA28, C_IND, 1, 32'h66);
		push_step("btb_frozen_target", 1, 32'hA08, encode_jalr(5, 6), C_IND, 1, 1, 32'h12345678);
		push_step("btb_frozen_alias", 1, 32'hA28, encode_jalr(5, 6), C_IND, 1, 0, 32'hA2C);
		push_step("not_a_branch", 1, 32'hB00, 32'h00108093, C_NONE, 0, 0, 32'h0); // addi
		push_step("idle_cond", 0, 32'h100, encode_branch(64), C_COND, 0, 0, 32'h0);
		push_step("idle_call", 0, 32'hB04, encode_jal(1, 8), C_CALL, 0, 0, 32'h0);
		push_step("ret_after_idle_call", 1, 32'hB0C, encode_jalr(0, 1), C_RET, 1, 0, 32'hB10);
		for (int n = 0; n < RANDOM_STEPS; n++) begin
			take_bits(3, row);
			take_bits(1, taken);
			take_bits(3, fetch_row);
			retire_next(1, 32'h4000 + row * 4, C_COND, taken[0], 32'h0);
			pc = 32'h4000 + fetch_row * 4; // row number equals the word offset here
			push_step($sformatf("random_%0d", n), 1, pc, encode_branch(8), C_COND, 1,
				pht_model[fetch_row] >= 2, pc + 32'd8);
		end
	endtask

	task automatic check_bit(input string test, input string what, input logic expected,
			input logic actual);
		if (actual !== expected) begin
			errors++;
			$display("ERROR %s %s: expected %b, actual %b", test, what, expected, actual);
		end
	endtask

	task automatic check_addr(input string test, input logic [`BP_XLEN-1:0] expected,
			input logic [`BP_XLEN-1:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("ERROR %s target: expected %h, actual %h", test, expected, actual);
		end
	endtask

	task automatic check_class(input string test, input predictor_pkg::branch_class_t expected,
			input predictor_pkg::branch_class_t actual);
		if (actual !== expected) begin
			errors++;
			$display("ERROR %s class: expected %s, actual %s (%0d)", test, expected.name(),
				actual.name(), actual);
		end
	endtask

	initial begin
		clock         = 1'b0;
		reset         = 1'b1;
		enable        = 1'b1;
		fetch_valid   = 1'b0;
		fetch_pc      = '0;
		fetch_instr   = '0;
		retire_valid  = 1'b0;
		retire_pc     = '0;
		retire_class  = C_NONE;
		retire_taken  = 1'b0;
		retire_target = '0;
		lfsr          = 17'd68782;
		pending        = '0;
		pending.enable = 1'b1;
		foreach (pht_model[r])
			pht_model[r] = 0;
		build_table();
		cycle_limit = steps.size() + RESET_CYCLES + MARGIN;
		repeat (RESET_CYCLES) @(posedge clock);
		#2;
		reset = 1'b0;
		foreach (steps[i]) begin
			@(posedge clock);
			#2;
			enable        = steps[i].enable;
			fetch_valid   = steps[i].fetch_valid;
			fetch_pc      = steps[i].fetch_pc;
			fetch_instr   = steps[i].fetch_instr;
			retire_valid  = steps[i].retire_valid;
			retire_pc     = steps[i].retire_pc;
			retire_class  = steps[i].retire_class;
			retire_taken  = steps[i].retire_taken;
			retire_target = steps[i].retire_target;
			#10; // mid cycle, outputs settled
			check_class(names[i], steps[i].exp_class, i_branch_predictor.fetch_class);
			check_bit(names[i], "valid", steps[i].exp_valid, predict_valid);
			check_bit(names[i], "taken", steps[i].exp_taken, predict_taken);
			if (steps[i].exp_valid)
				check_addr(names[i], steps[i].exp_target, predict_target);
		end
		$display("%0d steps checked, %0d errors", steps.size(), errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: source/bp_settings.svh
/* sizes of the branch predictor tables; all row and slot counts must be powers of two
   of at least two, since the index is taken straight from the address bits */
`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

// address and instruction width
`define BP_XLEN 32

// pattern history table rows, one two-bit counter each
`define BP_PHT_ROWS 8

// branch target buffer entries, direct mapped
`define BP_BTB_ROWS 8

// return address stack slots
`define BP_RAS_DEPTH 4

`endif

// File: source/branch_predecoder.sv
/* JALR gets no immediate target here; its direct_target is the fall-through pc + 4.
   funct3 is not checked, so reserved encodings under the branch opcodes still classify */
`default_nettype none
`timescale 1ns/100ps
`include "bp_settings.svh"

module branch_predecoder (
	input  wire logic [`BP_XLEN-1:0]          fetch_pc,
	input  wire rv_isa_pkg::instr_word_t      fetch_instr,
	output predictor_pkg::branch_class_t      fetch_class,
	output logic [`BP_XLEN-1:0]               direct_target
);

	logic [6:0]          opcode;
	logic [4:0]          rd;
	logic [4:0]          rs1;
	logic [`BP_XLEN-1:0] b_offset;
	logic [`BP_XLEN-1:0] j_offset;

	assign opcode = fetch_instr.raw[6:0];

	// rd sits at the same bits in J and I formats, rs1 at the same bits in B and I
	assign rd  = fetch_instr.j.rd;
	assign rs1 = fetch_instr.b.rs1;

	// B-type offset, bit 0 is always zero
	assign b_offset = {
		{(`BP_XLEN-13){fetch_instr.b.imm_12}},
		fetch_instr.b.imm_12,
		fetch_instr.b.imm_11,
		fetch_instr.b.imm_10_5,
		fetch_instr.b.imm_4_1,
		1'b0
	};

	// J-type offset, +-1 MiB range
	assign j_offset = {
		{(`BP_XLEN-21){fetch_instr.j.imm_20}},
		fetch_instr.j.imm_20,
		fetch_instr.j.imm_19_12,
		fetch_instr.j.imm_11,
		fetch_instr.j.imm_10_1,
		1'b0
	};

	always_comb begin
		fetch_class   = predictor_pkg::CLASS_NONE;
		direct_target = fetch_pc + `BP_XLEN'd4; // fall-through unless pc-relative

		case (opcode)
			rv_isa_pkg::OP_BRANCH: begin
				fetch_class   = predictor_pkg::CLASS_COND;
				direct_target = fetch_pc + b_offset;
			end
			rv_isa_pkg::OP_JAL: begin
				if (rd == rv_isa_pkg::REG_RA) begin
					fetch_class = predictor_pkg::CLASS_CALL;
				end else begin
					fetch_class = predictor_pkg::CLASS_JUMP;
				end
				direct_target = fetch_pc + j_offset;
			end
			rv_isa_pkg::OP_JALR: begin
				// return hint takes priority over the link check
				if (rd == rv_isa_pkg::REG_ZERO && rs1 == rv_isa_pkg::REG_RA) begin
					fetch_class = predictor_pkg::CLASS_RETURN;
				end else if (rd == rv_isa_pkg::REG_RA) begin
					fetch_class = predictor_pkg::CLASS_CALL;
				end else begin
					fetch_class = predictor_pkg::CLASS_INDIRECT;
				end
			end
			default: begin
				fetch_class = predictor_pkg::CLASS_NONE;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: source/branch_predictor.sv
/* all outputs are combinational from the fetch inputs; a JALR call is predicted to
   its fall-through address. enable freezes training only, the return stack still runs */
`default_nettype none
`timescale 1ns/100ps
`include "bp_settings.svh"

module branch_predictor (
	input  wire logic                         clock,
	input  wire logic                         reset,
	input  wire logic                         enable,
	input  wire logic                         fetch_valid,
	input  wire logic [`BP_XLEN-1:0]          fetch_pc,
	input  wire rv_isa_pkg::instr_word_t      fetch_instr,
	input  wire logic                         retire_valid,
	input  wire logic [`BP_XLEN-1:0]          retire_pc,
	input  wire predictor_pkg::branch_class_t retire_class,
	input  wire logic                         retire_taken,
	input  wire logic [`BP_XLEN-1:0]          retire_target,
	output logic                              predict_valid,
	output logic                              predict_taken,
	output logic [`BP_XLEN-1:0]               predict_target
);

	predictor_pkg::branch_class_t fetch_class;
	logic [`BP_XLEN-1:0]          direct_target;
	logic                         pht_lookup;
	logic                         pht_taken;
	logic                         btb_hit;
	logic [`BP_XLEN-1:0]          btb_target;
	logic                         btb_write;
	logic                         ras_push;
	logic                         ras_pop;
	logic                         ras_valid;
	logic [`BP_XLEN-1:0]          ras_addr;
	logic                         taken;

	assign pht_lookup = fetch_valid && fetch_class == predictor_pkg::CLASS_COND;
	assign ras_push   = fetch_valid && fetch_class == predictor_pkg::CLASS_CALL;
	assign ras_pop    = fetch_valid && fetch_class == predictor_pkg::CLASS_RETURN;
	assign btb_write  = enable && retire_valid && retire_taken
		&& retire_class == predictor_pkg::CLASS_INDIRECT;

	branch_predecoder i_branch_predecoder (
		.fetch_pc      (fetch_pc),
		.fetch_instr   (fetch_instr),
		.fetch_class   (fetch_class),
		.direct_target (direct_target)
	);

	pht_counter_table i_pht_counter_table (
		.clock         (clock),
		.reset         (reset),
		.enable        (enable),
		.lookup        (pht_lookup),
		.lookup_pc     (fetch_pc),
		.retire_valid  (retire_valid),
		.retire_pc     (retire_pc),
		.retire_class  (retire_class),
		.retire_taken  (retire_taken),
		.predict_taken (pht_taken)
	);

	branch_target_buffer i_branch_target_buffer (
		.clock        (clock),
		.reset        (reset),
		.lookup_pc    (fetch_pc),
		.hit          (btb_hit),
		.target       (btb_target),
		.write        (btb_write),
		.write_pc     (retire_pc),
		.write_target (retire_target)
	);

	return_address_stack i_return_address_stack (
		.clock     (clock),
		.reset     (reset),
		.push      (ras_push),
		.push_addr (fetch_pc),
		.pop       (ras_pop),
		.top_valid (ras_valid),
		.top_addr  (ras_addr)
	);

	always_comb begin
		taken          = 1'b0;
		predict_target = direct_target; // also the answer when nothing is taken
		case (fetch_class)
			predictor_pkg::CLASS_COND: taken = pht_taken;
			predictor_pkg::CLASS_JUMP,
			predictor_pkg::CLASS_CALL: taken = 1'b1;
			predictor_pkg::CLASS_RETURN: begin
				taken = ras_valid; // empty stack falls through
				if (ras_valid) begin
					predict_target = ras_addr;
				end
			end
			predictor_pkg::CLASS_INDIRECT: begin
				taken = btb_hit;
				if (btb_hit) begin
					predict_target = btb_target;
				end
			end
			default: taken = 1'b0;
		endcase
	end

	assign predict_valid = fetch_valid && fetch_class != predictor_pkg::CLASS_NONE;
	assign predict_taken = predict_valid && taken;

endmodule

`default_nettype wire

// File: source/branch_target_buffer.sv
/* direct mapped, full tag above the index; a read in the write cycle sees old contents.
   no replacement policy, a new write simply evicts the row */
`default_nettype none
`timescale 1ns/100ps
`include "bp_settings.svh"

module branch_target_buffer (
	input  wire logic                clock,
	input  wire logic                reset,
	input  wire logic [`BP_XLEN-1:0] lookup_pc,
	output logic                     hit,
	output logic [`BP_XLEN-1:0]      target,
	input  wire logic                write,
	input  wire logic [`BP_XLEN-1:0] write_pc,
	input  wire logic [`BP_XLEN-1:0] write_target
);

	localparam int INDEX_BITS = $clog2(`BP_BTB_ROWS);
	localparam int TAG_BITS   = `BP_XLEN - INDEX_BITS - 2;

	logic [`BP_BTB_ROWS-1:0] valid_q;
	logic [TAG_BITS-1:0]     tag_mem    [`BP_BTB_ROWS];
	logic [`BP_XLEN-1:0]     target_mem [`BP_BTB_ROWS];

	logic [INDEX_BITS-1:0] lookup_index;
	logic [TAG_BITS-1:0]   lookup_tag;
	logic [INDEX_BITS-1:0] write_index;
	logic [TAG_BITS-1:0]   write_tag;

	assign lookup_index = lookup_pc[INDEX_BITS+1:2];
	assign lookup_tag   = lookup_pc[`BP_XLEN-1:INDEX_BITS+2];
	assign write_index  = write_pc[INDEX_BITS+1:2];
	assign write_tag    = write_pc[`BP_XLEN-1:INDEX_BITS+2];

	// aliasing pcs share a row but differ in the tag
	assign hit    = valid_q[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
	assign target = target_mem[lookup_index];

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= '0;
		end else if (write) begin
			valid_q[write_index] <= 1'b1;
		end
	end

	// tag and target storage, meaningful only under valid_q
	always_ff @(posedge clock) begin
		if (write) begin
			tag_mem[write_index]    <= write_tag;
			target_mem[write_index] <= write_target;
		end
	end

	// a pc written in one cycle hits with its new target in the next
	a_write_then_hit: assert property (@(posedge clock) disable iff (reset)
		write |=> lookup_pc != $past(write_pc) || (hit && target == $past(write_target)));

endmodule

`default_nettype wire

// File: source/pht_counter_table.sv
/* one two-bit counter per row, indexed by pc bits above the byte offset, no history.
   a retire to the row being looked up is forwarded into the same cycle's prediction */
`default_nettype none
`timescale 1ns/100ps
`include "bp_settings.svh"

module pht_counter_table (
	input  wire logic                         clock,
	input  wire logic                         reset,
	input  wire logic                         enable,
	input  wire logic                         lookup,
	input  wire logic [`BP_XLEN-1:0]          lookup_pc,
	input  wire logic                         retire_valid,
	input  wire logic [`BP_XLEN-1:0]          retire_pc,
	input  wire predictor_pkg::branch_class_t retire_class,
	input  wire logic                         retire_taken,
	output logic                              predict_taken
);

	localparam int INDEX_BITS = $clog2(`BP_PHT_ROWS);

	predictor_pkg::counter_t [`BP_PHT_ROWS-1:0] pht;
	predictor_pkg::counter_t [`BP_PHT_ROWS-1:0] next_pht;

	logic [INDEX_BITS-1:0] lookup_index;
	logic [INDEX_BITS-1:0] retire_index;
	logic                  retire_cond;
	logic                  retire_return;
	logic                  update;
	logic [1:0]            lookup_state;

	assign lookup_index = lookup_pc[INDEX_BITS+1:2]; // skip byte offset
	assign retire_index = retire_pc[INDEX_BITS+1:2];

	assign retire_cond   = retire_class == predictor_pkg::CLASS_COND;
	assign retire_return = retire_class == predictor_pkg::CLASS_RETURN;
	assign update        = enable && retire_valid && retire_cond;

	// saturating step of the retired row
	always_comb begin
		next_pht = pht;
		if (update) begin
			case (pht[retire_index])
				predictor_pkg::STRONG_NT: next_pht[retire_index] =
					retire_taken ? predictor_pkg::WEAK_NT : predictor_pkg::STRONG_NT;
				predictor_pkg::WEAK_NT: next_pht[retire_index] =
					retire_taken ? predictor_pkg::WEAK_T : predictor_pkg::STRONG_NT;
				predictor_pkg::WEAK_T: next_pht[retire_index] =
					retire_taken ? predictor_pkg::STRONG_T : predictor_pkg::WEAK_NT;
				predictor_pkg::STRONG_T: next_pht[retire_index] =
					retire_taken ? predictor_pkg::STRONG_T : predictor_pkg::WEAK_T;
				default: next_pht[retire_index] = predictor_pkg::STRONG_NT;
			endcase
		end
	end

	// read the next state so a same-cycle retire is already visible
	assign lookup_state  = next_pht[lookup_index];
	assign predict_taken = lookup ? lookup_state[1] : 1'b0;

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `BP_PHT_ROWS; i++) begin
				pht[i] <= predictor_pkg::STRONG_NT;
			end
		end else begin
			pht <= next_pht;
		end
	end

	// returns are unconditional, they must never train a counter
	a_return_no_train: assert property (@(posedge clock) disable iff (reset)
		(retire_valid && retire_return) |=> $stable(pht));

endmodule

`default_nettype wire

// File: source/predictor_pkg.sv
/* state and class types shared by the predictor blocks */
`default_nettype none

package predictor_pkg;

	// two-bit saturating counter, the top bit is the taken prediction
	typedef enum logic [1:0] {
		STRONG_NT = 2'b00,
		WEAK_NT   = 2'b01,
		WEAK_T    = 2'b10,
		STRONG_T  = 2'b11
	} counter_t;

	// kind of control transfer, from predecode at fetch and from the core at retire
	typedef enum logic [2:0] {
		CLASS_NONE     = 3'd0,
		CLASS_COND     = 3'd1, // conditional branch, B-type
		CLASS_JUMP     = 3'd2, // JAL without link to ra
		CLASS_CALL     = 3'd3, // JAL or JALR writing ra
		CLASS_RETURN   = 3'd4, // JALR x0, 0(ra)
		CLASS_INDIRECT = 3'd5  // any other JALR
	} branch_class_t;

endpackage

`default_nettype wire

// File: source/return_address_stack.sv
/* circular, overflow drops the oldest return address; no repair after a misprediction.
   depth must be a power of two so the pointer wraps on its own */
`default_nettype none
`timescale 1ns/100ps
`include "bp_settings.svh"

module return_address_stack (
	input  wire logic                clock,
	input  wire logic                reset,
	input  wire logic                push,
	input  wire logic [`BP_XLEN-1:0] push_addr,
	input  wire logic                pop,
	output logic                     top_valid,
	output logic [`BP_XLEN-1:0]      top_addr
);

	localparam int PTR_BITS = $clog2(`BP_RAS_DEPTH);
	localparam logic [PTR_BITS:0] FULL = PTR_BITS'(`BP_RAS_DEPTH - 1) + 1'b1;

	logic [`BP_XLEN-1:0] slots [`BP_RAS_DEPTH];
	logic [PTR_BITS-1:0] top_ptr; // slot of the newest entry
	logic [PTR_BITS:0]   count;   // saturates at FULL

	assign top_valid = count != '0;
	assign top_addr  = slots[top_ptr];

	always_ff @(posedge clock) begin
		if (reset) begin
			top_ptr <= '0;
			count   <= '0;
		end else if (push) begin
			top_ptr <= top_ptr + 1'b1;
			if (count != FULL) begin
				count <= count + 1'b1;
			end
		end else if (pop && top_valid) begin
			top_ptr <= top_ptr - 1'b1; // empty pop leaves state alone
			count   <= count - 1'b1;
		end
	end

	// return lands after the call instruction
	always_ff @(posedge clock) begin
		if (push) begin
			slots[top_ptr + 1'b1] <= push_addr + `BP_XLEN'd4;
		end
	end

	// one fetch per cycle, so call and return never coincide
	a_no_push_pop: assert property (@(posedge clock) disable iff (reset) !(push && pop));

endmodule

`default_nettype wire

// File: source/rv_isa_pkg.sv
/* RV32I instruction word views needed by branch predecode; no compressed formats */
`default_nettype none

package rv_isa_pkg;

	// only the control transfer opcodes matter to the predictor
	typedef enum logic [6:0] {
		OP_BRANCH = 7'b1100011,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111
	} opcode_t;

	// architectural register numbers used for call and return hints
	localparam logic [4:0] REG_ZERO = 5'd0;
	localparam logic [4:0] REG_RA   = 5'd1;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_format_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_format_t;

	// one fetched word, read as B-type or J-type depending on the opcode
	typedef union packed {
		b_format_t   b;
		j_format_t   j;
		logic [31:0] raw;
	} instr_word_t;

endpackage

`default_nettype wire

// File: src.f
+incdir+source
source/rv_isa_pkg.sv
source/predictor_pkg.sv
source/branch_predecoder.sv
source/pht_counter_table.sv
source/branch_target_buffer.sv
source/return_address_stack.sv
source/branch_predictor.sv
sim/tb_branch_predictor.sv
